// File: list.f
hw/fdd_pkg.sv
hw/step_decoder.sv
hw/head_positioner.sv
hw/track_loader.sv
hw/track_buffer_ram.sv
hw/fdd_drive_top.sv
sim/tb_clock.sv
sim/fdd_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= fdd_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/fdd_tb.sv
`timescale 1ns/100ps

module fdd_tb;
    localparam int max_tracks = 5;
    localparam int delay_ms = 3;
    localparam int clks_per_ms = 20;
    localparam int blocks_per_track = 2;
    localparam int track_bytes = blocks_per_track * fdd_pkg::block_bytes;
    localparam int buf_aw = $clog2(track_bytes);
    localparam int settle_lo = (delay_ms - 1) * clks_per_ms - 4;  // surely still settling.
    localparam int settle_hi = (delay_ms + 1) * clks_per_ms + 4;  // surely settled.
    localparam int n_steps = 2 * (max_tracks + 1) + 40 + 8;
    localparam int n_loads = 9;
    localparam int load_cycles = 4 * track_bytes + 100;
    localparam int limit_cycles = n_steps * (2 * settle_hi + 10) + n_loads * load_cycles + 50;

    logic                          clk;
    logic                          reset;
    logic [1:0]                    usel;
    logic                          stepn;
    logic                          sdirn;
    logic                          siden;
    logic                          disk_mounted;
    logic                          disk_sides;
    logic [fdd_pkg::track_w-1:0]   track;
    logic                          track0n;
    logic                          track_ready;
    logic [buf_aw-1:0]             buffer_addr;
    logic [7:0]                    buffer_q;
    logic [fdd_pkg::lba_w-1:0]     sd_lba;
    logic [fdd_pkg::blk_cnt_w-1:0] sd_blk_cnt;
    logic                          sd_rd;
    logic                          sd_ack;
    logic [fdd_pkg::sd_addr_w-1:0] sd_buff_addr;
    logic [7:0]                    sd_buff_dout;
    logic                          sd_buff_wr;

    int          cycle = 0;
    int          exp_cyl [fdd_pkg::num_drives];
    int          last_move [fdd_pkg::num_drives];
    logic [31:0] stim_rng = 32'd64195;
    logic [31:0] sd_rng = 32'd64195;
    logic [31:0] last_req_lba;
    logic [31:0] rd_lba;
    logic        rd_active;
    logic        rd_pending = 1'b0;
    logic [buf_aw-1:0] rd_addr_q;

    tb_clock #(.period_ns(100)) u_clock (.clk(clk));

    fdd_drive_top #(
        .max_tracks(max_tracks),
        .delay_ms(delay_ms),
        .clks_per_ms(clks_per_ms),
        .blocks_per_track(blocks_per_track)
    ) uut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // first block of a track side in the image.
    function automatic logic [31:0] expected_lba(input int cyl, input logic side, input logic sides);
        int key;
        key = sides ? 2 * cyl + int'(side) : cyl;
        return 32'(key * blocks_per_track);
    endfunction

    function automatic logic [7:0] expected_byte(input logic [31:0] lba, input int off);
        return 8'(int'(lba) * 29 + off + (off >> 8) * 71);
    endfunction

    function automatic int next_cyl(input int cyl, input logic up);
        if (up && cyl < max_tracks - 1) return cyl + 1;
        if (!up && cyl > 0) return cyl - 1;
        return cyl;  // head against the stop.
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("FAILED at %0t ns: %s is %0d, expected %0d",
                                $time, what, got, expected));
        end
    endtask

    task automatic step_head(input int drive, input logic up);
        int elapsed;
        int new_cyl;
        @(negedge clk);
        usel = 2'(drive);
        sdirn = !up;
        @(negedge clk);
        check_value("track of selected drive", 32'(track), 32'(exp_cyl[drive]));
        elapsed = cycle - last_move[drive];
        if (elapsed >= settle_lo && elapsed < settle_hi) begin
            repeat (settle_hi - elapsed) @(negedge clk);  // skip the uncertain window.
            elapsed = settle_hi;
        end
        new_cyl = (elapsed >= settle_hi) ? next_cyl(exp_cyl[drive], up) : exp_cyl[drive];
        if (new_cyl != exp_cyl[drive]) last_move[drive] = cycle;
        stepn = 1'b0;
        @(negedge clk);
        check_value("track one edge after step", 32'(track), 32'(exp_cyl[drive]));
        @(negedge clk);
        check_value("track two edges after step", 32'(track), 32'(new_cyl));
        check_value("track0n", 32'(track0n), 32'(new_cyl != 0));
        stepn = 1'b1;
        exp_cyl[drive] = new_cyl;
    endtask

    // sd card model serving one block run per request.
    task automatic serve_request();
        logic [31:0] req_lba;
        int delay;
        req_lba = sd_lba;
        check_value("sd_blk_cnt at request", 32'(sd_blk_cnt), 32'(blocks_per_track));
        sd_rng = xorshift32(sd_rng);
        delay = 1 + int'(sd_rng % 8);
        repeat (delay) begin
            @(negedge clk);
            check_value("sd_rd before ack", 32'(sd_rd), 32'd1);
            check_value("sd_lba before ack", sd_lba, req_lba);
        end
        sd_ack = 1'b1;
        @(negedge clk);
        sd_ack = 1'b0;
        last_req_lba = req_lba;
        for (int off = 0; off < track_bytes; off++) begin
            sd_buff_addr = fdd_pkg::sd_addr_w'(off);
            sd_buff_dout = expected_byte(req_lba, off);
            sd_buff_wr = 1'b1;
            @(negedge clk);
        end
        sd_buff_wr = 1'b0;
    endtask

    task automatic verify_track();
        logic [31:0] exp_lba;
        int waited;
        waited = 0;
        repeat (2) @(negedge clk);
        while (!track_ready) begin
            @(negedge clk);
            waited++;
            if (waited > load_cycles) abort_run("track_ready did not rise after a track change");
        end
        exp_lba = expected_lba(exp_cyl[usel], !siden, disk_sides);
        check_value("requested sd_lba", last_req_lba, exp_lba);
        check_value("sd_lba", sd_lba, exp_lba);
        rd_lba = exp_lba;
        for (int a = 0; a < track_bytes; a++) begin
            buffer_addr = buf_aw'(a);
            rd_active = 1'b1;
            @(negedge clk);
        end
        rd_active = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        rd_pending <= rd_active;
        rd_addr_q <= buffer_addr;
    end

    // buffer reads and the idle sd side.
    always @(negedge clk) begin
        if (rd_pending) begin
            check_value("buffer_q", 32'(buffer_q), 32'(expected_byte(rd_lba, int'(rd_addr_q))));
        end
        if (!reset && !disk_mounted) check_value("sd_rd with no disk", 32'(sd_rd), 32'd0);
    end

    always begin
        @(negedge clk);
        if (!reset && sd_rd) serve_request();
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        abort_run("watchdog timeout: the run did not finish in time");
    end

    initial begin
        reset = 1'b1;
        usel = 2'd0;
        stepn = 1'b1;
        sdirn = 1'b1;
        siden = 1'b1;
        disk_mounted = 1'b0;
        disk_sides = 1'b0;
        buffer_addr = '0;
        sd_ack = 1'b0;
        sd_buff_addr = '0;
        sd_buff_dout = '0;
        sd_buff_wr = 1'b0;
        rd_active = 1'b0;
        rd_lba = '0;
        last_req_lba = '0;
        for (int d = 0; d < fdd_pkg::num_drives; d++) begin
            exp_cyl[d] = 0;
            last_move[d] = -1000;  // no move yet.
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("track after reset", 32'(track), 32'd0);
        check_value("track0n after reset", 32'(track0n), 32'd0);
        check_value("sd_rd after reset", 32'(sd_rd), 32'd0);
        check_value("track_ready after reset", 32'(track_ready), 32'd0);
        for (int i = 0; i < 2 * (max_tracks + 1); i++) begin
            repeat (settle_hi) @(negedge clk);
            step_head(0, i < max_tracks + 1);  // run into both stops.
        end
        for (int i = 0; i < 40; i++) begin
            stim_rng = xorshift32(stim_rng);
            step_head(int'(stim_rng % 4), stim_rng[8]);
            if (stim_rng[12:11] == 2'd0) repeat (settle_hi) @(negedge clk);
        end
        @(negedge clk);
        disk_mounted = 1'b1;
        verify_track();
        for (int i = 0; i < 8; i++) begin
            stim_rng = xorshift32(stim_rng);
            @(negedge clk);
            disk_sides = i[1];
            siden = !i[0];
            if (i[2]) step_head(int'(stim_rng % 4), stim_rng[8]);
            else usel = 2'(stim_rng % 4);
            verify_track();
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int period_ns = 100
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #(period_ns / 2) clk = ~clk;

endmodule

// File: hw/fdd_drive_top.sv
`timescale 1ns/100ps

module fdd_drive_top #(
    parameter int max_tracks = 80,
    parameter int delay_ms = 3,
    parameter int clks_per_ms = 50000,
    parameter int blocks_per_track = 16,
    localparam int buf_aw = $clog2(blocks_per_track * fdd_pkg::block_bytes)
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [1:0]                    usel,
    input  logic                          stepn,
    input  logic                          sdirn,
    input  logic                          siden,
    input  logic                          disk_mounted,
    input  logic                          disk_sides,
    output logic [fdd_pkg::track_w-1:0]   track,
    output logic                          track0n,
    output logic                          track_ready,
    input  logic [buf_aw-1:0]             buffer_addr,
    output logic [7:0]                    buffer_q,
    output logic [fdd_pkg::lba_w-1:0]     sd_lba,
    output logic [fdd_pkg::blk_cnt_w-1:0] sd_blk_cnt,
    output logic                          sd_rd,
    input  logic                          sd_ack,
    input  logic [fdd_pkg::sd_addr_w-1:0] sd_buff_addr,
    input  logic [7:0]                    sd_buff_dout,
    input  logic                          sd_buff_wr
);
    logic [fdd_pkg::num_drives-1:0] step;
    logic                           dir_in;
    logic                           ms_tick;
    logic                           side;
    logic                           wr_en;
    logic [fdd_pkg::track_w-1:0]    cyl [fdd_pkg::num_drives];

    assign side = ~siden;
    assign track = cyl[usel];
    assign track0n = track != '0;  // low at cylinder 0.

    step_decoder #(
        .clks_per_ms(clks_per_ms)
    ) u_step_decoder (
        .clk(clk),
        .reset(reset),
        .usel(usel),
        .stepn(stepn),
        .sdirn(sdirn),
        .step(step),
        .dir_in(dir_in),
        .ms_tick(ms_tick)
    );

    for (genvar g = 0; g < fdd_pkg::num_drives; g++) begin : g_drive
        head_positioner #(
            .max_tracks(max_tracks),
            .delay_ms(delay_ms)
        ) u_head_positioner (
            .clk(clk),
            .reset(reset),
            .step(step[g]),
            .dir_in(dir_in),
            .ms_tick(ms_tick),
            .cyl(cyl[g])
        );
    end

    track_loader #(
        .blocks_per_track(blocks_per_track)
    ) u_track_loader (
        .clk(clk),
        .reset(reset),
        .usel(usel),
        .cyl(track),
        .side(side),
        .disk_mounted(disk_mounted),
        .disk_sides(disk_sides),
        .sd_ack(sd_ack),
        .sd_buff_addr(sd_buff_addr),
        .sd_buff_wr(sd_buff_wr),
        .sd_lba(sd_lba),
        .sd_blk_cnt(sd_blk_cnt),
        .sd_rd(sd_rd),
        .track_ready(track_ready),
        .wr_en(wr_en)
    );

    track_buffer_ram #(
        .blocks_per_track(blocks_per_track)
    ) u_track_buffer_ram (
        .clk(clk),
        .wr_en(wr_en),
        .wr_addr(sd_buff_addr[buf_aw-1:0]),
        .wr_data(sd_buff_dout),
        .rd_addr(buffer_addr),
        .rd_data(buffer_q)
    );

endmodule

// File: hw/track_buffer_ram.sv
`timescale 1ns/100ps

module track_buffer_ram #(
    parameter int blocks_per_track = 16,
    localparam int depth = blocks_per_track * fdd_pkg::block_bytes,
    localparam int aw = $clog2(depth)
) (
    input  logic          clk,
    input  logic          wr_en,
    input  logic [aw-1:0] wr_addr,
    input  logic [7:0]    wr_data,
    input  logic [aw-1:0] rd_addr,
    output logic [7:0]    rd_data
);
    logic [7:0] mem [depth];  // one side of one track.

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hw/track_loader.sv
`timescale 1ns/100ps

module track_loader #(
    parameter int blocks_per_track = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [1:0]                    usel,
    input  logic [fdd_pkg::track_w-1:0]   cyl,
    input  logic                          side,
    input  logic                          disk_mounted,
    input  logic                          disk_sides,
    input  logic                          sd_ack,
    input  logic [fdd_pkg::sd_addr_w-1:0] sd_buff_addr,
    input  logic                          sd_buff_wr,
    output logic [fdd_pkg::lba_w-1:0]     sd_lba,
    output logic [fdd_pkg::blk_cnt_w-1:0] sd_blk_cnt,
    output logic                          sd_rd,
    output logic                          track_ready,
    output logic                          wr_en
);
    localparam int track_bytes = blocks_per_track * fdd_pkg::block_bytes;
    localparam int cnt_w = $clog2(track_bytes + 1);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(track_bytes - 1);
    localparam int key_w = 2 + fdd_pkg::track_w + 2;
    localparam int pad_w = fdd_pkg::lba_w - fdd_pkg::track_w - 1;

    fdd_pkg::load_state_t state;

    logic [key_w-1:0]          cur_key;
    logic [key_w-1:0]          loaded_key;
    logic                      key_changed;
    logic [fdd_pkg::track_w:0] track_key;
    logic [fdd_pkg::lba_w-1:0] lba_next;
    logic [cnt_w-1:0]          byte_cnt;
    logic                      last_byte;

    // anything that selects a different image region.
    assign cur_key = {usel, cyl, side, disk_mounted};
    assign key_changed = cur_key != loaded_key;

    // interleave the sides on double sided images.
    assign track_key = disk_sides ? {cyl, side} : {1'b0, cyl};
    assign lba_next = {{pad_w{1'b0}}, track_key} * blocks_per_track[fdd_pkg::lba_w-1:0];
    assign sd_blk_cnt = blocks_per_track[fdd_pkg::blk_cnt_w-1:0];

    assign wr_en = (state == fdd_pkg::stream) && sd_buff_wr
                   && (int'(sd_buff_addr) < track_bytes);
    assign last_byte = wr_en && (byte_cnt == last_cnt);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= fdd_pkg::idle;
            loaded_key <= '0;
            sd_lba <= '0;
            sd_rd <= 1'b0;
            track_ready <= 1'b0;
            byte_cnt <= '0;
        end else begin
            case (state)
                fdd_pkg::idle, fdd_pkg::ready: begin
                    if (key_changed) begin
                        loaded_key <= cur_key;
                        track_ready <= 1'b0;
                        if (disk_mounted) begin
                            state <= fdd_pkg::request;
                            sd_lba <= lba_next;
                            sd_rd <= 1'b1;
                        end else begin
                            state <= fdd_pkg::idle;  // nothing to fetch.
                        end
                    end
                end
                fdd_pkg::request: begin
                    byte_cnt <= '0;
                    if (sd_ack) begin
                        sd_rd <= 1'b0;
                        state <= fdd_pkg::stream;
                    end
                end
                fdd_pkg::stream: begin
                    if (wr_en) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                    if (last_byte) begin
                        // key moved mid stream, so refetch from idle.
                        if (key_changed) begin
                            state <= fdd_pkg::idle;
                        end else begin
                            state <= fdd_pkg::ready;
                            track_ready <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= fdd_pkg::idle;
                end
            endcase
        end
    end

    sd_rd_held: assert property (
        @(posedge clk) disable iff (reset)
        sd_rd && !sd_ack |=> sd_rd && $stable(sd_lba)
    ) else $error("sd_rd or sd_lba changed before sd_ack");

endmodule

// File: hw/head_positioner.sv
`timescale 1ns/100ps

module head_positioner #(
    parameter int max_tracks = 80,
    parameter int delay_ms = 3
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        step,
    input  logic                        dir_in,
    input  logic                        ms_tick,
    output logic [fdd_pkg::track_w-1:0] cyl
);
    localparam int settle_w = $clog2(delay_ms + 1) + 1;
    localparam logic [settle_w-1:0] settle_init = settle_w'(delay_ms);
    localparam int top_cyl = max_tracks - 1;

    logic [settle_w-1:0] settle;
    logic                can_up;
    logic                can_down;
    logic                accept;

    assign can_up = dir_in && (cyl != top_cyl[fdd_pkg::track_w-1:0]);
    assign can_down = !dir_in && (cyl != '0);
    assign accept = step && (settle == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cyl <= '0;
            settle <= '0;
        end else if (accept && can_up) begin
            cyl <= cyl + 1'b1;
            settle <= settle_init;
        end else if (accept && can_down) begin
            cyl <= cyl - 1'b1;
            settle <= settle_init;
        end else if (ms_tick && settle != '0) begin
            settle <= settle - 1'b1;  // head still settling.
        end
    end

    cyl_in_range: assert property (
        @(posedge clk) disable iff (reset)
        int'(cyl) < max_tracks
    ) else $error("cylinder %0d out of range", cyl);

endmodule

// File: hw/step_decoder.sv
`timescale 1ns/100ps

module step_decoder #(
    parameter int clks_per_ms = 50000
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [1:0]                      usel,
    input  logic                            stepn,
    input  logic                            sdirn,
    output logic [fdd_pkg::num_drives-1:0]  step,
    output logic                            dir_in,
    output logic                            ms_tick
);
    localparam int div_w = $clog2(clks_per_ms + 1);
    localparam logic [div_w-1:0] div_last = div_w'(clks_per_ms - 1);

    logic             stepn_q;
    logic             step_fall;
    logic [div_w-1:0] div_cnt;

    assign step_fall = stepn_q & ~stepn;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stepn_q <= 1'b0;     // no spurious step if held low.
            step <= '0;
            dir_in <= 1'b0;
        end else begin
            stepn_q <= stepn;
            dir_in <= ~sdirn;    // high steps toward higher cylinders.
            for (int i = 0; i < fdd_pkg::num_drives; i++) begin
                step[i] <= step_fall && (usel == 2'(i));
            end
        end
    end

    // millisecond tick for the settle timers.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            ms_tick <= 1'b0;
        end else if (div_cnt == div_last) begin
            div_cnt <= '0;
            ms_tick <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            ms_tick <= 1'b0;
        end
    end

endmodule

// File: hw/fdd_pkg.sv
package fdd_pkg;

    // drive bank.
    localparam int num_drives = 4;      // one per usel code.

    // sd block geometry.
    localparam int block_bytes = 512;

    // widths on the sd and controller side.
    localparam int track_w = 7;         // up to 128 cylinders.
    localparam int lba_w = 32;
    localparam int blk_cnt_w = 6;
    localparam int sd_addr_w = 14;      // byte offset within a block run.

    typedef enum logic [1:0] {
        idle,
        request,
        stream,
        ready
    } load_state_t;

endpackage
